//--- design/input_port.sv
/*
 * router input port
 * per-channel flit buffers, XY route of the selected head flit,
 * round-robin choice among channels and credit return upstream
 */

`default_nettype none
`timescale 1ns/100ps

module input_port
  import router_cfg_pkg::*, router_types_pkg::*;
#(
  parameter coord_t router_x = '0,
  parameter coord_t router_y = '0
) (
  input  wire         clk_i,
  input  wire         arst_n_i,
  // link from the upstream router
  input  wire         data_v_i,
  input  wire flit_t  data_i,
  // request towards the switch allocator
  output logic        req_v_o,
  output port_oh_t    req_dir_o,
  output flit_t       req_flit_o,
  input  wire         grant_i,
  // credit back to the upstream router
  output logic        credit_v_o,
  output vc_id_t      credit_id_o
);

  flit_t                    buf_q    [num_vc][vc_depth];
  logic [vc_ptr_width-1:0]  wr_ptr_q [num_vc];
  logic [vc_ptr_width-1:0]  rd_ptr_q [num_vc];
  credit_cnt_t              count_q  [num_vc];

  vc_id_t   in_vc;
  vc_oh_t   push;
  vc_oh_t   pop;
  vc_oh_t   vc_nonempty;
  vc_id_t   rr_q;
  vc_id_t   sel_vc;
  logic     sel_v;
  logic     pop_v;
  flit_t    head_flit;
  coord_t   dst_x;
  coord_t   dst_y;

  function automatic logic [vc_ptr_width-1:0] next_ptr(input logic [vc_ptr_width-1:0] ptr);
    if (ptr == vc_ptr_width'(vc_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==========================================================================
  // channel buffers
  // ==========================================================================

  assign in_vc = data_i[vc_id_lsb +: vc_id_width];
  assign pop_v = grant_i & sel_v;

  // upstream only sends with a credit, so the target buffer has room
  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      buf_q[in_vc][wr_ptr_q[in_vc]] <= data_i;
    end
  end

  for (genvar c = 0; c < num_vc; c++) begin : gen_vc
    assign push[c]        = data_v_i && (in_vc == vc_id_t'(c));
    assign pop[c]         = pop_v && (sel_vc == vc_id_t'(c));
    assign vc_nonempty[c] = (count_q[c] != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q[c] <= '0;
        rd_ptr_q[c] <= '0;
        count_q[c]  <= '0;
      end else begin
        if (push[c]) begin
          wr_ptr_q[c] <= next_ptr(wr_ptr_q[c]);
        end
        if (pop[c]) begin
          rd_ptr_q[c] <= next_ptr(rd_ptr_q[c]);
        end
        // push and pop together leave the fill level unchanged
        case ({push[c], pop[c]})
          2'b10:   count_q[c] <= count_q[c] + credit_cnt_t'(1);
          2'b01:   count_q[c] <= count_q[c] - credit_cnt_t'(1);
          default: count_q[c] <= count_q[c];
        endcase
      end
    end
  end

  // ==========================================================================
  // local round-robin among non-empty channels
  // ==========================================================================

  always_comb begin : local_arb
    int idx;
    sel_v  = 1'b0;
    sel_vc = rr_q;
    for (int n = 0; n < num_vc; n++) begin
      idx = (int'(rr_q) + n) % num_vc;
      if (!sel_v && vc_nonempty[idx]) begin
        sel_v  = 1'b1;
        sel_vc = vc_id_t'(idx);
      end
    end
  end

  assign head_flit = buf_q[sel_vc][rd_ptr_q[sel_vc]];
  assign dst_x     = head_flit[dst_x_lsb +: coord_width];
  assign dst_y     = head_flit[dst_y_lsb +: coord_width];

  // XY routing, x first, then y, local when both match
  always_comb begin
    req_dir_o = '0;
    if (dst_x > router_x) begin
      req_dir_o[port_east] = 1'b1;
    end else if (dst_x < router_x) begin
      req_dir_o[port_west] = 1'b1;
    end else if (dst_y > router_y) begin
      req_dir_o[port_north] = 1'b1;
    end else if (dst_y < router_y) begin
      req_dir_o[port_south] = 1'b1;
    end else begin
      req_dir_o[port_local] = 1'b1;
    end
  end

  assign req_v_o    = sel_v;
  assign req_flit_o = head_flit;

  // ==========================================================================
  // pointer update and credit return on grant
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q        <= '0;
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o <= pop_v;
      if (pop_v) begin
        credit_id_o <= sel_vc;
        // channel after the granted one gets priority next
        rr_q <= (sel_vc == vc_id_t'(num_vc - 1)) ? '0 : sel_vc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/output_credits.sv
/*
 * downstream credit tracking for one output port
 * one counter per virtual channel and lowest-free channel select
 */

`default_nettype none
`timescale 1ns/100ps

module output_credits
  import router_cfg_pkg::*, router_types_pkg::*;
(
  input  wire          clk_i,
  input  wire          arst_n_i,
  // credit returned by the downstream router
  input  wire          credit_v_i,
  input  wire vc_id_t  credit_id_i,
  // flit sent on this output
  input  wire          consume_v_i,
  input  wire vc_id_t  consume_id_i,
  output logic         free_v_o,
  output vc_id_t       free_id_o
);

  credit_cnt_t cnt_q [num_vc];
  vc_oh_t      inc;
  vc_oh_t      dec;
  vc_oh_t      has_credit;

  for (genvar c = 0; c < num_vc; c++) begin : gen_cnt
    assign inc[c]        = credit_v_i && (credit_id_i == vc_id_t'(c));
    assign dec[c]        = consume_v_i && (consume_id_i == vc_id_t'(c));
    assign has_credit[c] = (cnt_q[c] != '0);

    // downstream buffers start empty, so every channel holds vc_depth
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q[c] <= credit_cnt_t'(vc_depth);
      end else begin
        case ({inc[c], dec[c]})
          2'b10:   cnt_q[c] <= cnt_q[c] + credit_cnt_t'(1);
          2'b01:   cnt_q[c] <= cnt_q[c] - credit_cnt_t'(1);
          default: cnt_q[c] <= cnt_q[c];
        endcase
      end
    end
  end

  // lowest numbered channel with a credit wins
  always_comb begin
    free_v_o  = 1'b0;
    free_id_o = '0;
    for (int c = num_vc - 1; c >= 0; c--) begin
      if (has_credit[c]) begin
        free_v_o  = 1'b1;
        free_id_o = vc_id_t'(c);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/router_cfg_pkg.sv
/*
 * router configuration constants
 * port count and port indices, virtual channel count and buffer depth,
 * field widths and bit positions of a single-flit packet
 */

`default_nettype none

package router_cfg_pkg;

  // five ports, mesh directions first and local last
  localparam int num_ports      = 5;
  localparam int port_north     = 0;
  localparam int port_east      = 1;
  localparam int port_south     = 2;
  localparam int port_west      = 3;
  localparam int port_local     = 4;
  localparam int port_idx_width = $clog2(num_ports);

  // virtual channels and their buffers
  localparam int num_vc           = 2;
  localparam int vc_depth         = 2;
  localparam int vc_id_width      = $clog2(num_vc);
  localparam int vc_ptr_width     = $clog2(vc_depth);
  localparam int credit_cnt_width = $clog2(vc_depth + 1);

  // flit layout, msb to lsb: vc id, dst x, dst y, payload
  localparam int coord_width   = 3;
  localparam int payload_width = 16;
  localparam int payload_lsb   = 0;
  localparam int dst_y_lsb     = payload_lsb + payload_width;
  localparam int dst_x_lsb     = dst_y_lsb + coord_width;
  localparam int vc_id_lsb     = dst_x_lsb + coord_width;
  localparam int flit_width    = vc_id_lsb + vc_id_width;

endpackage

`default_nettype wire

//--- design/router_types_pkg.sv
/*
 * router data types
 * flit, mesh coordinate, payload, channel id and one-hot masks,
 * credit counter width
 */

`default_nettype none

package router_types_pkg;

  import router_cfg_pkg::*;

  // ==========================================================================
  // flit and its fields
  // ==========================================================================

  // whole single-flit packet as it travels on a link
  typedef logic [flit_width-1:0]    flit_t;

  // one mesh coordinate, x or y
  typedef logic [coord_width-1:0]   coord_t;

  typedef logic [payload_width-1:0] payload_t;

  // ==========================================================================
  // channel and port selection
  // ==========================================================================

  // virtual channel number, also carried in the flit
  typedef logic [vc_id_width-1:0]   vc_id_t;

  // one bit per virtual channel
  typedef logic [num_vc-1:0]        vc_oh_t;

  // one bit per router port, indexed by port_north .. port_local
  typedef logic [num_ports-1:0]     port_oh_t;

  // free slots of one channel, counts 0 up to vc_depth
  typedef logic [credit_cnt_width-1:0] credit_cnt_t;

endpackage

`default_nettype wire

//--- design/switch_allocator.sv
/*
 * switch allocator
 * per-output round-robin among requesting inputs, gated by a free
 * downstream channel, plus grant pulses back to the input ports
 */

`default_nettype none
`timescale 1ns/100ps

module switch_allocator
  import router_cfg_pkg::*, router_types_pkg::*;
(
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  // requests from the input ports
  input  wire  [num_ports-1:0]           req_v_i,
  input  wire port_oh_t [num_ports-1:0]  req_dir_i,
  // credits from the downstream routers
  input  wire  [num_ports-1:0]           credit_v_i,
  input  wire vc_id_t [num_ports-1:0]    credit_id_i,
  output logic [num_ports-1:0]           grant_o,
  // per output towards switch traversal
  output logic [num_ports-1:0]           out_v_o,
  output port_oh_t [num_ports-1:0]       out_sel_o,
  output vc_id_t [num_ports-1:0]         out_vc_o
);

  for (genvar o = 0; o < num_ports; o++) begin : gen_out
    port_oh_t                   req_mask;
    logic [port_idx_width-1:0]  rr_q;
    logic [port_idx_width-1:0]  win_idx;
    logic                       win_v;
    logic                       free_v;
    vc_id_t                     free_id;

    // inputs whose head flit wants this output
    for (genvar i = 0; i < num_ports; i++) begin : gen_req
      assign req_mask[i] = req_v_i[i] & req_dir_i[i][o];
    end

    always_comb begin : global_arb
      int idx;
      win_v   = 1'b0;
      win_idx = rr_q;
      for (int n = 0; n < num_ports; n++) begin
        idx = (int'(rr_q) + n) % num_ports;
        if (!win_v && req_mask[idx]) begin
          win_v   = 1'b1;
          win_idx = port_idx_width'(idx);
        end
      end
    end

    output_credits u_output_credits (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .credit_v_i   (credit_v_i[o]),
      .credit_id_i  (credit_id_i[o]),
      .consume_v_i  (out_v_o[o]),
      .consume_id_i (free_id),
      .free_v_o     (free_v),
      .free_id_o    (free_id)
    );

    // no free channel means no grant, the flit stays buffered
    assign out_v_o[o]   = win_v & free_v;
    assign out_sel_o[o] = out_v_o[o] ? (port_oh_t'(1) << win_idx) : '0;
    assign out_vc_o[o]  = free_id;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rr_q <= '0;
      end else if (out_v_o[o]) begin
        rr_q <= (win_idx == port_idx_width'(num_ports - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

  // ==========================================================================
  // grants back to the inputs
  // ==========================================================================

  // an input asks for one output only, so at most one select bit is set
  always_comb begin
    grant_o = '0;
    for (int o = 0; o < num_ports; o++) begin
      grant_o = grant_o | out_sel_o[o];
    end
  end

endmodule

`default_nettype wire

//--- design/switch_traversal.sv
/*
 * switch traversal stage
 * one-hot crossbar, output channel id rewrite and output registers
 */

`default_nettype none
`timescale 1ns/100ps

module switch_traversal
  import router_cfg_pkg::*, router_types_pkg::*;
(
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  input  wire flit_t [num_ports-1:0]     req_flit_i,
  input  wire  [num_ports-1:0]           out_v_i,
  input  wire port_oh_t [num_ports-1:0]  out_sel_i,
  input  wire vc_id_t [num_ports-1:0]    out_vc_i,
  output logic [num_ports-1:0]           data_v_o,
  output flit_t [num_ports-1:0]          data_o
);

  flit_t [num_ports-1:0] xbar_flit;
  flit_t [num_ports-1:0] out_flit;

  for (genvar o = 0; o < num_ports; o++) begin : gen_out
    // and-or mux, the select is one-hot or zero
    always_comb begin
      xbar_flit[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        if (out_sel_i[o][i]) begin
          xbar_flit[o] = xbar_flit[o] | req_flit_i[i];
        end
      end
    end

    // keep destination and payload, take the channel granted downstream
    always_comb begin
      out_flit[o] = '0;
      out_flit[o][vc_id_lsb +: vc_id_width] = out_vc_i[o];
      out_flit[o][dst_x_lsb +: coord_width] = coord_t'(xbar_flit[o][dst_x_lsb +: coord_width]);
      out_flit[o][dst_y_lsb +: coord_width] = coord_t'(xbar_flit[o][dst_y_lsb +: coord_width]);
      out_flit[o][payload_lsb +: payload_width] =
        payload_t'(xbar_flit[o][payload_lsb +: payload_width]);
    end

    always_ff @(posedge clk_i) begin
      if (out_v_i[o]) begin
        data_o[o] <= out_flit[o];
      end
    end
  end

  // ==========================================================================
  // output valid
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= out_v_i;
    end
  end

endmodule

`default_nettype wire

//--- design/vc_router.sv
/*
 * five-port virtual channel router with credit flow control
 * input ports, switch allocator and switch traversal stage
 */

`default_nettype none
`timescale 1ns/100ps

module vc_router
  import router_cfg_pkg::*, router_types_pkg::*;
#(
  parameter coord_t router_x = '0,
  parameter coord_t router_y = '0
) (
  input  wire                          clk_i,
  input  wire                          arst_n_i,
  // links from the neighbours, indexed by port
  input  wire  [num_ports-1:0]         data_v_i,
  input  wire flit_t [num_ports-1:0]   data_i,
  output logic [num_ports-1:0]         credit_v_o,
  output vc_id_t [num_ports-1:0]       credit_id_o,
  // links towards the neighbours
  output logic [num_ports-1:0]         data_v_o,
  output flit_t [num_ports-1:0]        data_o,
  input  wire  [num_ports-1:0]         credit_v_i,
  input  wire vc_id_t [num_ports-1:0]  credit_id_i
);

  logic     [num_ports-1:0] req_v;
  port_oh_t [num_ports-1:0] req_dir;
  flit_t    [num_ports-1:0] req_flit;
  logic     [num_ports-1:0] grant;
  logic     [num_ports-1:0] out_v;
  port_oh_t [num_ports-1:0] out_sel;
  vc_id_t   [num_ports-1:0] out_vc;

  // ==========================================================================
  // input ports
  // ==========================================================================

  for (genvar p = 0; p < num_ports; p++) begin : gen_in_port
    input_port #(
      .router_x (router_x),
      .router_y (router_y)
    ) u_input_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .req_v_o     (req_v[p]),
      .req_dir_o   (req_dir[p]),
      .req_flit_o  (req_flit[p]),
      .grant_i     (grant[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p])
    );
  end

  // ==========================================================================
  // allocation and traversal
  // ==========================================================================

  switch_allocator u_switch_allocator (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_v_i     (req_v),
    .req_dir_i   (req_dir),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .grant_o     (grant),
    .out_v_o     (out_v),
    .out_sel_o   (out_sel),
    .out_vc_o    (out_vc)
  );

  switch_traversal u_switch_traversal (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_flit_i (req_flit),
    .out_v_i    (out_v),
    .out_sel_i  (out_sel),
    .out_vc_i   (out_vc),
    .data_v_o   (data_v_o),
    .data_o     (data_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_vc_router.sv
/*
 * testbench for the five-port virtual channel router
 * row table, upstream and downstream credit models, scoreboard and
 * typed compare tasks
 */

`default_nettype none
`timescale 1ns/100ps

module tb_vc_router
  import router_cfg_pkg::*, router_types_pkg::*;
();

  localparam int       max_rows     = 64;
  localparam int       ret_delay    = 3;
  localparam payload_t payload_base = 16'hA000;
  localparam coord_t   node_x       = 3'd2;
  localparam coord_t   node_y       = 3'd2;

  logic                     clk_i;
  logic                     arst_n_i;
  logic     [num_ports-1:0] data_v_i;
  flit_t    [num_ports-1:0] data_i;
  logic     [num_ports-1:0] credit_v_o;
  vc_id_t   [num_ports-1:0] credit_id_o;
  logic     [num_ports-1:0] data_v_o;
  flit_t    [num_ports-1:0] data_o;
  logic     [num_ports-1:0] credit_v_i;
  vc_id_t   [num_ports-1:0] credit_id_i;

  // stimulus rows whose payload is payload_base plus the row index
  int       row_port      [max_rows];
  vc_id_t   row_vc        [max_rows];
  coord_t   row_x         [max_rows];
  coord_t   row_y         [max_rows];
  port_oh_t row_exp       [max_rows];
  logic     row_hold      [max_rows];
  logic     row_with_prev [max_rows];
  int       n_rows;

  // one destination per output as seen from node (2,2)
  coord_t   dir_x   [num_ports] = '{3'd2, 3'd4, 3'd2, 3'd0, 3'd2};
  coord_t   dir_y   [num_ports] = '{3'd5, 3'd1, 3'd0, 3'd3, 3'd2};
  port_oh_t dir_exp [num_ports] = '{5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b10000};

  // scoreboard and credit models
  int   drive_cyc [max_rows];
  int   out_cyc   [max_rows];
  logic seen      [max_rows];
  int   delivered;
  int   cyc;
  int   out_cnt   [num_ports];
  int   up_cred   [num_ports][num_vc];
  int   in_flight [num_ports][num_vc];
  int   dn_cred   [num_ports][num_vc];
  int   ret_port  [$];
  int   ret_vc    [$];
  int   ret_due   [$];
  int   held_port [$];
  int   held_vc   [$];

  vc_router #(
    .router_x (node_x),
    .router_y (node_y)
  ) u_dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ==========================================================================
  // compare and helper tasks
  // ==========================================================================

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_flit(input flit_t act, input flit_t exp, input string what);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s flit %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_port(input port_oh_t act, input port_oh_t exp, input string what);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_vc(input vc_id_t act, input vc_id_t exp, input string what);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail at %0t: %s %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  // XY rule takes x first, then y, and local when both match
  function automatic port_oh_t xy_port(input coord_t x, input coord_t y);
    port_oh_t dir;
    dir = '0;
    if (x > node_x) dir[port_east] = 1'b1;
    else if (x < node_x) dir[port_west] = 1'b1;
    else if (y > node_y) dir[port_north] = 1'b1;
    else if (y < node_y) dir[port_south] = 1'b1;
    else dir[port_local] = 1'b1;
    return dir;
  endfunction

  function automatic flit_t make_flit(input vc_id_t vc, input coord_t x, input coord_t y,
                                      input payload_t pl);
    flit_t f;
    f = '0;
    f[vc_id_lsb +: vc_id_width]     = vc;
    f[dst_x_lsb +: coord_width]     = x;
    f[dst_y_lsb +: coord_width]     = y;
    f[payload_lsb +: payload_width] = pl;
    return f;
  endfunction

  function automatic int flits_in_flight();
    int sum;
    sum = 0;
    for (int p = 0; p < num_ports; p++) begin
      for (int c = 0; c < num_vc; c++) begin
        sum += in_flight[p][c];
      end
    end
    return sum;
  endfunction

  task automatic add_row(input int port, input vc_id_t vc, input coord_t x, input coord_t y,
                         input port_oh_t exp, input logic hold, input logic with_prev);
    row_port[n_rows]      = port;
    row_vc[n_rows]        = vc;
    row_x[n_rows]         = x;
    row_y[n_rows]         = y;
    row_exp[n_rows]       = exp;
    row_hold[n_rows]      = hold;
    row_with_prev[n_rows] = with_prev;
    n_rows++;
  endtask

  // ==========================================================================
  // per-cycle monitor on the falling edge where outputs are stable
  // ==========================================================================

  task automatic observe_outputs();
    int    r;
    int    vc;
    flit_t f;
    for (int o = 0; o < num_ports; o++) begin
      if (data_v_o[o]) begin
        f  = data_o[o];
        r  = int'(payload_t'(f[payload_lsb +: payload_width] - payload_base));
        if (r >= n_rows || seen[r]) begin
          stop_on_error($sformatf("unexpected or repeated flit %h left port %0d", f, o));
        end
        // lowest channel that the model still counts a credit for
        vc = -1;
        for (int c = num_vc - 1; c >= 0; c--) begin
          if (dn_cred[o][c] > 0) vc = c;
        end
        if (vc < 0) begin
          stop_on_error($sformatf("port %0d sent a flit without a downstream credit", o));
        end
        check_port(port_oh_t'(1) << o, row_exp[r], "output port");
        check_vc(f[vc_id_lsb +: vc_id_width], vc_id_t'(vc), "output channel");
        check_flit(f, make_flit(vc_id_t'(vc), row_x[r], row_y[r], payload_base + payload_t'(r)),
                   "output");
        dn_cred[o][vc]--;
        seen[r]    = 1'b1;
        out_cyc[r] = cyc;
        delivered++;
        out_cnt[o]++;
        if (row_hold[r]) begin
          held_port.push_back(o);
          held_vc.push_back(vc);
        end else begin
          ret_port.push_back(o);
          ret_vc.push_back(vc);
          ret_due.push_back(cyc + ret_delay);
        end
      end
    end
  endtask

  task automatic observe_credits();
    int vc;
    for (int p = 0; p < num_ports; p++) begin
      if (credit_v_o[p]) begin
        vc = int'(credit_id_o[p]);
        if (in_flight[p][vc] == 0) begin
          stop_on_error($sformatf("credit on port %0d channel %0d without a flit", p, vc));
        end
        in_flight[p][vc]--;
        up_cred[p][vc]++;
      end
    end
  endtask

  // downstream model returns at most one credit per port and cycle
  task automatic return_credits();
    logic [num_ports-1:0] used;
    int                   p;
    int                   vc;
    // credits driven a cycle ago reached the DUT at the edge just passed
    for (int q = 0; q < num_ports; q++) begin
      if (credit_v_i[q]) begin
        dn_cred[q][credit_id_i[q]]++;
      end
    end
    used       = '0;
    credit_v_i = '0;
    while (ret_due.size() > 0 && ret_due[0] <= cyc && !used[ret_port[0]]) begin
      p  = ret_port.pop_front();
      vc = ret_vc.pop_front();
      void'(ret_due.pop_front());
      used[p]        = 1'b1;
      credit_v_i[p]  = 1'b1;
      credit_id_i[p] = vc_id_t'(vc);
    end
  endtask

  task automatic next_cycle();
    @(negedge clk_i);
    cyc++;
    observe_outputs();
    observe_credits();
    return_credits();
  endtask

  task automatic release_held();
    while (held_port.size() > 0) begin
      ret_port.push_back(held_port.pop_front());
      ret_vc.push_back(held_vc.pop_front());
      ret_due.push_back(cyc);
    end
  endtask

  // ==========================================================================
  // stimulus and waits
  // ==========================================================================

  task automatic wait_credits(input int first, input int last);
    logic ok;
    for (int t = 0; t < 200; t++) begin
      ok = 1'b1;
      for (int i = first; i < last; i++) begin
        if (up_cred[row_port[i]][row_vc[i]] == 0) ok = 1'b0;
      end
      if (ok) return;
      next_cycle();
    end
    stop_on_error("no upstream credit came back within 200 cycles");
  endtask

  task automatic drive_row(input int r);
    int p;
    p = row_port[r];
    data_v_i[p] = 1'b1;
    data_i[p]   = make_flit(row_vc[r], row_x[r], row_y[r], payload_base + payload_t'(r));
    up_cred[p][row_vc[r]]--;
    in_flight[p][row_vc[r]]++;
    drive_cyc[r] = cyc;
  endtask

  // rows marked with_prev go out in the same cycle as the row before
  task automatic apply_rows(input int first, input int last);
    int r;
    int g;
    r = first;
    while (r < last) begin
      g = r + 1;
      while (g < last && row_with_prev[g]) g++;
      wait_credits(r, g);
      for (int i = r; i < g; i++) drive_row(i);
      next_cycle();
      data_v_i = '0;
      r = g;
    end
  endtask

  task automatic wait_drained();
    for (int t = 0; t < 1000; t++) begin
      if (delivered == n_rows && flits_in_flight() == 0) return;
      next_cycle();
    end
    stop_on_error("flits were still inside the router after 1000 cycles");
  endtask

  task automatic settle_credits();
    for (int t = 0; t < 100; t++) begin
      if (ret_due.size() == 0) return;
      next_cycle();
    end
    stop_on_error("downstream credits were not all returned within 100 cycles");
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    int     first;
    int     east_base;
    coord_t x;
    coord_t y;
    void'($urandom(23427));
    arst_n_i    = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    n_rows      = 0;
    delivered   = 0;
    cyc         = 0;
    for (int p = 0; p < num_ports; p++) begin
      out_cnt[p] = 0;
      for (int c = 0; c < num_vc; c++) begin
        up_cred[p][c]   = vc_depth;
        dn_cred[p][c]   = vc_depth;
        in_flight[p][c] = 0;
      end
    end
    for (int r = 0; r < max_rows; r++) seen[r] = 1'b0;

    repeat (16) next_cycle();
    arst_n_i = 1'b1;
    for (int t = 0; t < 8; t++) begin
      next_cycle();
      check_port(data_v_o, '0, "output valid after reset");
      check_port(credit_v_o, '0, "credit valid after reset");
    end

    // single flit on an idle router
    add_row(port_local, 1'b0, 3'd4, 3'd2, dir_exp[port_east], 1'b0, 1'b0);
    apply_rows(0, 1);
    wait_drained();
    if (out_cyc[0] - drive_cyc[0] != 2) begin
      stop_on_error($sformatf("Fail at %0t: latency %0d cycles, expected 2", $time,
                              out_cyc[0] - drive_cyc[0]));
    end

    // every direction from every input, then random destinations
    first = n_rows;
    for (int p = 0; p < num_ports; p++) begin
      for (int d = 0; d < num_ports; d++) begin
        add_row(p, vc_id_t'(d % num_vc), dir_x[d], dir_y[d], dir_exp[d], 1'b0, 1'b0);
      end
    end
    for (int i = 0; i < 15; i++) begin
      x = coord_t'($urandom_range(7));
      y = coord_t'($urandom_range(7));
      add_row(int'($urandom_range(num_ports - 1)), vc_id_t'($urandom_range(1)), x, y,
              xy_port(x, y), 1'b0, 1'b0);
    end
    apply_rows(first, n_rows);
    wait_drained();
    settle_credits();
    for (int p = 0; p < num_ports; p++) begin
      for (int c = 0; c < num_vc; c++) begin
        if (up_cred[p][c] != vc_depth) begin
          stop_on_error($sformatf("Fail at %0t: port %0d channel %0d holds %0d credits",
                                  $time, p, c, up_cred[p][c]));
        end
      end
    end

    // with East credits held back only the credited flits may leave
    first     = n_rows;
    east_base = out_cnt[port_east];
    add_row(port_west,  1'b0, 3'd5, 3'd2, dir_exp[port_east], 1'b1, 1'b0);
    add_row(port_west,  1'b1, 3'd6, 3'd2, dir_exp[port_east], 1'b1, 1'b0);
    add_row(port_local, 1'b0, 3'd5, 3'd1, dir_exp[port_east], 1'b1, 1'b0);
    add_row(port_local, 1'b1, 3'd7, 3'd3, dir_exp[port_east], 1'b1, 1'b0);
    add_row(port_north, 1'b0, 3'd3, 3'd0, dir_exp[port_east], 1'b1, 1'b0);
    add_row(port_south, 1'b0, 3'd4, 3'd7, dir_exp[port_east], 1'b1, 1'b0);
    apply_rows(first, n_rows);
    repeat (20) next_cycle();
    if (out_cnt[port_east] - east_base != num_vc * vc_depth) begin
      stop_on_error($sformatf("Fail at %0t: %0d flits left East without credits back",
                              $time, out_cnt[port_east] - east_base));
    end
    release_held();
    wait_drained();
    release_held();
    settle_credits();

    // two inputs to the local output in the same cycle
    first = n_rows;
    add_row(port_north, 1'b0, 3'd2, 3'd2, dir_exp[port_local], 1'b0, 1'b0);
    add_row(port_east,  1'b0, 3'd2, 3'd2, dir_exp[port_local], 1'b0, 1'b1);
    add_row(port_north, 1'b1, 3'd2, 3'd2, dir_exp[port_local], 1'b0, 1'b0);
    add_row(port_east,  1'b1, 3'd2, 3'd2, dir_exp[port_local], 1'b0, 1'b1);
    apply_rows(first, n_rows);
    wait_drained();
    settle_credits();

    if (delivered == n_rows && flits_in_flight() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_on_error("flits were lost inside the router");
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vc_router -f vc_router.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_vc_router > sim.log 2>&1

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"

//--- vc_router.f
design/router_cfg_pkg.sv
design/router_types_pkg.sv
design/input_port.sv
design/output_credits.sv
design/switch_allocator.sv
design/switch_traversal.sv
design/vc_router.sv
dv/tb_vc_router.sv
